// File: common/scdb_macros.svh
`ifndef SCDB_MACROS_SVH
`define SCDB_MACROS_SVH

// channel side
`define SCDB_N_CHANNELS 4
`define SCDB_CHANS_PER_SCAN 2

// data widths
`define SCDB_SAMPLE_W 16
`define SCDB_ADDR_W 6
// stored as sample count minus one
`define SCDB_LEN_W 4
`define SCDB_TAG_W 12

// header fifo holds 8 entries
`define SCDB_HDR_DEPTH_LOG2 3
// cycles from a header pop to the first accepted sample read
`define SCDB_HDR_WAIT 2

`endif

// File: common/scdb_data_pkg.sv
`default_nettype none

`include "scdb_macros.svh"

package scdb_data_pkg;

  typedef logic [`SCDB_SAMPLE_W-1:0] sample_t;
  typedef logic [`SCDB_ADDR_W-1:0] scdb_addr_t;
  // 0 to 64 words, one bit wider than an address
  typedef logic [`SCDB_ADDR_W:0] scdb_used_t;
  typedef logic [`SCDB_LEN_W-1:0] wfm_len_t;
  typedef logic [`SCDB_TAG_W-1:0] evt_tag_t;
  typedef logic [$clog2(`SCDB_N_CHANNELS)-1:0] chan_idx_t;

  // channel header
  //   [15:4]  event tag
  //   [3:0]   length, samples minus one
  typedef logic [`SCDB_TAG_W+`SCDB_LEN_W-1:0] wvb_hdr_t;

  // header of a waveform in the shared buffer
  //   [25:14] event tag
  //   [13:12] channel index
  //   [11:6]  start address
  //   [5:0]   stop address
  typedef logic [`SCDB_TAG_W+$clog2(`SCDB_N_CHANNELS)+2*`SCDB_ADDR_W-1:0] scdb_hdr_t;

endpackage

`default_nettype wire

// File: common/scdb_ctrl_pkg.sv
`default_nettype none

package scdb_ctrl_pkg;

  // channel finder
  typedef enum logic [1:0] {
    FIND_IDLE,
    FIND_SCAN,
    FIND_READY
  } finder_state_t;

  // waveform writer
  typedef enum logic [1:0] {
    WR_IDLE,
    WR_HDR_CHECK,
    WR_COPY,
    WR_CLOSE
  } writer_state_t;

endpackage

`default_nettype wire

// File: rtl/chan_finder.sv
`timescale 1ns/1ps
`default_nettype none

`include "scdb_macros.svh"

module chan_finder
  import scdb_data_pkg::*;
  import scdb_ctrl_pkg::*;
(
  input  wire logic                        clk,
  input  wire logic                        i_rst_n,
  input  wire logic [`SCDB_N_CHANNELS-1:0] i_wvb_hdr_empty,
  input  wire logic                        i_hdr_taken,
  output logic                             o_wfm_ready,
  output chan_idx_t                        o_next_chan
);

  localparam int SCAN_W = `SCDB_CHANS_PER_SCAN;

  finder_state_t     state;
  chan_idx_t         base;
  chan_idx_t         win_chan [SCAN_W];
  logic [SCAN_W-1:0] win_ready;
  logic              hit;
  chan_idx_t         hit_chan;

  // sample the window starting at base
  always_ff @(posedge clk) begin
    for (int k = 0; k < SCAN_W; k++) begin
      win_chan[k] <= chan_idx_t'(base + k);
    end
  end

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      win_ready <= '0;
    end else begin
      for (int k = 0; k < SCAN_W; k++) begin
        win_ready[k] <= !i_wvb_hdr_empty[chan_idx_t'(base + k)];
      end
    end
  end

  // lowest ready slot of the window wins
  always_comb begin
    hit = 1'b0;
    hit_chan = win_chan[0];
    for (int k = SCAN_W - 1; k >= 0; k--) begin
      if (win_ready[k]) begin
        hit = 1'b1;
        hit_chan = win_chan[k];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      state <= FIND_IDLE;
      base <= '0;
      o_wfm_ready <= 1'b0;
      o_next_chan <= '0;
    end else begin
      case (state)
        FIND_IDLE: begin
          base <= chan_idx_t'(base + SCAN_W);
          state <= FIND_SCAN;
        end
        FIND_SCAN: begin
          if (hit) begin
            o_wfm_ready <= 1'b1;
            o_next_chan <= hit_chan;
            base <= chan_idx_t'(hit_chan + 1'b1);
            state <= FIND_READY;
          end else begin
            base <= chan_idx_t'(base + SCAN_W);
          end
        end
        FIND_READY: begin
          // window behind the held channel is already sampled, skip past it
          if (i_hdr_taken) begin
            o_wfm_ready <= 1'b0;
            base <= chan_idx_t'(base + SCAN_W);
            state <= FIND_SCAN;
          end
        end
        default: begin
          state <= FIND_IDLE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: scdb_writer/scdb_writer.sv
`timescale 1ns/1ps
`default_nettype none

`include "scdb_macros.svh"

module scdb_writer
  import scdb_data_pkg::*;
  import scdb_ctrl_pkg::*;
(
  input  wire logic                                  clk,
  input  wire logic                                  i_rst_n,
  input  wire logic                                  i_wfm_ready,
  input  wire chan_idx_t                             i_next_chan,
  input  wire wvb_hdr_t [`SCDB_N_CHANNELS-1:0]       i_wvb_hdr_data,
  input  wire sample_t  [`SCDB_N_CHANNELS-1:0]       i_wvb_data,
  input  wire logic                                  i_room_ok,
  input  wire scdb_addr_t                            i_wr_addr,
  output logic                                       o_hdr_taken,
  output logic          [`SCDB_N_CHANNELS-1:0]       o_wvb_hdr_rdreq,
  output logic          [`SCDB_N_CHANNELS-1:0]       o_wvb_rdreq,
  output logic          [`SCDB_N_CHANNELS-1:0]       o_wvb_rddone,
  output wfm_len_t                                   o_len,
  output logic                                       o_sample_wren,
  output sample_t                                    o_sample_wdata,
  output logic                                       o_hdr_wren,
  output scdb_hdr_t                                  o_hdr_wdata
);

  writer_state_t                 state;
  chan_idx_t                     chan;
  evt_tag_t                      tag;
  wfm_len_t                      len;
  wfm_len_t                      cnt;
  scdb_addr_t                    start_addr;
  scdb_addr_t                    stop_addr;
  logic                          pop_q;
  logic                          take;
  wvb_hdr_t                      next_hdr;
  logic [`SCDB_N_CHANNELS-1:0]   chan_sel;

  // a new waveform is taken from idle or straight out of close
  assign take = i_wfm_ready && (state == WR_IDLE || state == WR_CLOSE);
  assign next_hdr = i_wvb_hdr_data[i_next_chan];

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      state <= WR_IDLE;
      pop_q <= 1'b0;
      cnt <= '0;
    end else begin
      pop_q <= take;
      case (state)
        WR_IDLE, WR_CLOSE: begin
          if (take) begin
            state <= WR_HDR_CHECK;
          end else begin
            state <= WR_IDLE;
          end
        end
        WR_HDR_CHECK: begin
          // nothing is read from the channel until storage has room
          if (i_room_ok) begin
            cnt <= '0;
            state <= WR_COPY;
          end
        end
        WR_COPY: begin
          cnt <= cnt + 1'b1;
          if (cnt == len) begin
            state <= WR_CLOSE;
          end
        end
        default: begin
          state <= WR_IDLE;
        end
      endcase
    end
  end

  // waveform being moved
  always_ff @(posedge clk) begin
    if (take) begin
      chan <= i_next_chan;
      tag <= next_hdr[`SCDB_TAG_W+`SCDB_LEN_W-1:`SCDB_LEN_W];
      len <= next_hdr[`SCDB_LEN_W-1:0];
    end
    if (state == WR_HDR_CHECK && i_room_ok) begin
      start_addr <= i_wr_addr;
    end
  end

  always_comb begin
    chan_sel = '0;
    chan_sel[chan] = 1'b1;
  end

  // last sample lands at start plus length
  assign stop_addr = scdb_addr_t'(start_addr + len);

  assign o_hdr_taken = pop_q;
  assign o_wvb_hdr_rdreq = pop_q ? chan_sel : '0;
  assign o_wvb_rdreq = (state == WR_COPY) ? chan_sel : '0;
  assign o_wvb_rddone = (state == WR_CLOSE) ? chan_sel : '0;

  assign o_len = len;
  assign o_sample_wren = (state == WR_COPY);
  assign o_sample_wdata = i_wvb_data[chan];

  assign o_hdr_wren = (state == WR_CLOSE);
  assign o_hdr_wdata = {tag, chan, start_addr, stop_addr};

endmodule

`default_nettype wire

// File: scdb_storage/scdb_storage.sv
`timescale 1ns/1ps
`default_nettype none

`include "scdb_macros.svh"

module scdb_storage
  import scdb_data_pkg::*;
(
  input  wire logic       clk,
  input  wire logic       i_rst_n,
  input  wire wfm_len_t   i_len,
  input  wire logic       i_sample_wren,
  input  wire sample_t    i_sample_wdata,
  input  wire logic       i_hdr_wren,
  input  wire scdb_hdr_t  i_hdr_wdata,
  input  wire logic       i_hdr_pop,
  input  wire scdb_addr_t i_rd_addr,
  input  wire logic       i_release,
  input  wire scdb_addr_t i_release_addr,
  output logic            o_room_ok,
  output scdb_addr_t      o_wr_addr,
  output logic            o_hdr_empty,
  output scdb_hdr_t       o_hdr_data,
  output sample_t         o_rd_data
);

  localparam int MEM_WORDS = 1 << `SCDB_ADDR_W;
  localparam int HDR_DEPTH = 1 << `SCDB_HDR_DEPTH_LOG2;

  sample_t    mem [MEM_WORDS];
  scdb_addr_t wr_ptr;
  scdb_used_t used;
  scdb_used_t need;
  scdb_addr_t remain;

  scdb_hdr_t                       hdr_mem [HDR_DEPTH];
  logic [`SCDB_HDR_DEPTH_LOG2-1:0] hdr_wr_ptr;
  logic [`SCDB_HDR_DEPTH_LOG2-1:0] hdr_rd_ptr;
  logic [`SCDB_HDR_DEPTH_LOG2:0]   hdr_cnt;
  logic                            hdr_full;

  // sample memory, registered read
  always_ff @(posedge clk) begin
    if (i_sample_wren) begin
      mem[wr_ptr] <= i_sample_wdata;
    end
    o_rd_data <= mem[i_rd_addr];
  end

  // words left behind the released waveform
  assign remain = scdb_addr_t'(wr_ptr - i_release_addr - 1'b1);

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      wr_ptr <= '0;
      used <= '0;
    end else begin
      if (i_sample_wren) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (i_release) begin
        used <= scdb_used_t'(remain) + i_sample_wren;
      end else begin
        used <= used + i_sample_wren;
      end
    end
  end

  assign need = used + scdb_used_t'(i_len) + 1'b1;
  assign o_room_ok = (need <= MEM_WORDS) && !hdr_full;
  assign o_wr_addr = wr_ptr;

  // header fifo
  always_ff @(posedge clk) begin
    if (i_hdr_wren) begin
      hdr_mem[hdr_wr_ptr] <= i_hdr_wdata;
    end
    if (i_hdr_pop) begin
      o_hdr_data <= hdr_mem[hdr_rd_ptr];
    end
  end

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      hdr_wr_ptr <= '0;
      hdr_rd_ptr <= '0;
      hdr_cnt <= '0;
    end else begin
      if (i_hdr_wren) begin
        hdr_wr_ptr <= hdr_wr_ptr + 1'b1;
      end
      if (i_hdr_pop) begin
        hdr_rd_ptr <= hdr_rd_ptr + 1'b1;
      end
      hdr_cnt <= hdr_cnt + i_hdr_wren - i_hdr_pop;
    end
  end

  assign hdr_full = (hdr_cnt == HDR_DEPTH);
  assign o_hdr_empty = (hdr_cnt == '0);

endmodule

`default_nettype wire

// File: rtl/scdb_reader.sv
`timescale 1ns/1ps
`default_nettype none

`include "scdb_macros.svh"

module scdb_reader
  import scdb_data_pkg::*;
(
  input  wire logic      clk,
  input  wire logic      i_rst_n,
  input  wire logic      i_buf_hdr_rdreq,
  input  wire logic      i_buf_rdreq,
  input  wire logic      i_buf_rddone,
  input  wire scdb_hdr_t i_hdr_data,
  output logic           o_hdr_pop,
  output scdb_addr_t     o_rd_addr,
  output logic           o_release,
  output scdb_addr_t     o_release_addr
);

  localparam int WAIT_W = $clog2(`SCDB_HDR_WAIT + 1);

  logic [WAIT_W-1:0] wait_cnt;
  scdb_addr_t        start_addr;
  scdb_addr_t        stop_addr;
  logic              rd_accept;

  assign start_addr = i_hdr_data[2*`SCDB_ADDR_W-1:`SCDB_ADDR_W];
  assign stop_addr = i_hdr_data[`SCDB_ADDR_W-1:0];

  // reads held off while a header is fetched
  assign rd_accept = i_buf_rdreq && (wait_cnt == '0) && !i_buf_hdr_rdreq;

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      wait_cnt <= '0;
      o_rd_addr <= '0;
    end else begin
      if (i_buf_hdr_rdreq) begin
        wait_cnt <= WAIT_W'(1);
      end else if (wait_cnt == WAIT_W'(`SCDB_HDR_WAIT - 1)) begin
        wait_cnt <= '0;
        o_rd_addr <= start_addr;
      end else if (wait_cnt != '0) begin
        wait_cnt <= wait_cnt + 1'b1;
      end
      // stop sample repeats once reached
      if (rd_accept && o_rd_addr != stop_addr) begin
        o_rd_addr <= o_rd_addr + 1'b1;
      end
    end
  end

  assign o_hdr_pop = i_buf_hdr_rdreq;
  assign o_release = i_buf_rddone;
  assign o_release_addr = stop_addr;

endmodule

`default_nettype wire

// File: rtl/secondary_buffer.sv
`timescale 1ns/1ps
`default_nettype none

`include "scdb_macros.svh"

module secondary_buffer
  import scdb_data_pkg::*;
(
  input  wire logic                                  clk,
  input  wire logic                                  i_rst_n,
  input  wire logic     [`SCDB_N_CHANNELS-1:0]       i_wvb_hdr_empty,
  input  wire wvb_hdr_t [`SCDB_N_CHANNELS-1:0]       i_wvb_hdr_data,
  input  wire sample_t  [`SCDB_N_CHANNELS-1:0]       i_wvb_data,
  output logic          [`SCDB_N_CHANNELS-1:0]       o_wvb_hdr_rdreq,
  output logic          [`SCDB_N_CHANNELS-1:0]       o_wvb_rdreq,
  output logic          [`SCDB_N_CHANNELS-1:0]       o_wvb_rddone,
  input  wire logic                                  i_buf_hdr_rdreq,
  input  wire logic                                  i_buf_rdreq,
  input  wire logic                                  i_buf_rddone,
  output logic                                       o_buf_hdr_empty,
  output scdb_hdr_t                                  o_buf_hdr_data,
  output sample_t                                    o_buf_data
);

  // finder to writer
  logic       wfm_ready;
  chan_idx_t  next_chan;
  logic       hdr_taken;

  // writer to storage
  wfm_len_t   len;
  logic       sample_wren;
  sample_t    sample_wdata;
  logic       hdr_wren;
  scdb_hdr_t  hdr_wdata;
  scdb_addr_t wr_addr;
  logic       room_ok;

  // reader to storage
  logic       hdr_pop;
  scdb_addr_t rd_addr;
  logic       release_req;
  scdb_addr_t release_addr;

  chan_finder finder0 (
    .clk             (clk),
    .i_rst_n         (i_rst_n),
    .i_wvb_hdr_empty (i_wvb_hdr_empty),
    .i_hdr_taken     (hdr_taken),
    .o_wfm_ready     (wfm_ready),
    .o_next_chan     (next_chan)
  );

  scdb_writer writer0 (
    .clk             (clk),
    .i_rst_n         (i_rst_n),
    .i_wfm_ready     (wfm_ready),
    .i_next_chan     (next_chan),
    .i_wvb_hdr_data  (i_wvb_hdr_data),
    .i_wvb_data      (i_wvb_data),
    .i_room_ok       (room_ok),
    .i_wr_addr       (wr_addr),
    .o_hdr_taken     (hdr_taken),
    .o_wvb_hdr_rdreq (o_wvb_hdr_rdreq),
    .o_wvb_rdreq     (o_wvb_rdreq),
    .o_wvb_rddone    (o_wvb_rddone),
    .o_len           (len),
    .o_sample_wren   (sample_wren),
    .o_sample_wdata  (sample_wdata),
    .o_hdr_wren      (hdr_wren),
    .o_hdr_wdata     (hdr_wdata)
  );

  scdb_storage storage0 (
    .clk            (clk),
    .i_rst_n        (i_rst_n),
    .i_len          (len),
    .i_sample_wren  (sample_wren),
    .i_sample_wdata (sample_wdata),
    .i_hdr_wren     (hdr_wren),
    .i_hdr_wdata    (hdr_wdata),
    .i_hdr_pop      (hdr_pop),
    .i_rd_addr      (rd_addr),
    .i_release      (release_req),
    .i_release_addr (release_addr),
    .o_room_ok      (room_ok),
    .o_wr_addr      (wr_addr),
    .o_hdr_empty    (o_buf_hdr_empty),
    .o_hdr_data     (o_buf_hdr_data),
    .o_rd_data      (o_buf_data)
  );

  scdb_reader reader0 (
    .clk             (clk),
    .i_rst_n         (i_rst_n),
    .i_buf_hdr_rdreq (i_buf_hdr_rdreq),
    .i_buf_rdreq     (i_buf_rdreq),
    .i_buf_rddone    (i_buf_rddone),
    .i_hdr_data      (o_buf_hdr_data),
    .o_hdr_pop       (hdr_pop),
    .o_rd_addr       (rd_addr),
    .o_release       (release_req),
    .o_release_addr  (release_addr)
  );

endmodule

`default_nettype wire

// File: dv/wvb_channel_model.sv
`timescale 1ns/1ps
`default_nettype none

`include "scdb_macros.svh"

module wvb_channel_model
  import scdb_data_pkg::*;
(
  input  wire logic clk,
  input  wire logic i_hdr_rdreq,
  input  wire logic i_rdreq,
  input  wire logic i_rddone,
  output logic      o_hdr_empty,
  output wvb_hdr_t  o_hdr_data,
  output sample_t   o_data
);

  wvb_hdr_t hdr_q [$];
  sample_t  smp_q [$];
  int       done_cnt = 0;
  // set when a strobe hits an empty queue
  logic     bad_strobe = 1'b0;

  initial begin
    o_hdr_empty = 1'b1;
    o_hdr_data = '0;
    o_data = '0;
  end

  // samples go in before their header so the head is complete when shown
  task automatic add_sample(input sample_t s);
    smp_q.push_back(s);
    o_data = smp_q[0];
  endtask

  task automatic add_header(input wvb_hdr_t h);
    hdr_q.push_back(h);
    o_hdr_empty = 1'b0;
    o_hdr_data = hdr_q[0];
  endtask

  // show-ahead, the head moves on with each strobe
  always @(posedge clk) begin
    if (i_hdr_rdreq) begin
      if (hdr_q.size() == 0) begin
        bad_strobe = 1'b1;
      end else begin
        void'(hdr_q.pop_front());
      end
    end
    if (i_rdreq) begin
      if (smp_q.size() == 0) begin
        bad_strobe = 1'b1;
      end else begin
        void'(smp_q.pop_front());
      end
    end
    if (i_rddone) begin
      done_cnt = done_cnt + 1;
    end
    o_hdr_empty <= (hdr_q.size() == 0);
    o_hdr_data <= (hdr_q.size() != 0) ? hdr_q[0] : '0;
    o_data <= (smp_q.size() != 0) ? smp_q[0] : '0;
  end

endmodule

`default_nettype wire

// File: dv/secondary_buffer_props.sv
`timescale 1ns/1ps
`default_nettype none

`include "scdb_macros.svh"

module secondary_buffer_props (
  input wire logic                        clk,
  input wire logic                        i_rst_n,
  input wire logic [`SCDB_N_CHANNELS-1:0] i_wvb_hdr_rdreq,
  input wire logic [`SCDB_N_CHANNELS-1:0] i_wvb_rdreq,
  input wire logic [`SCDB_N_CHANNELS-1:0] i_wvb_rddone,
  input wire logic                        i_buf_hdr_empty
);

  // each strobe goes to a single channel
  a_strobe_onehot: assert property (@(posedge clk) disable iff (!i_rst_n)
    $onehot0(i_wvb_hdr_rdreq) && $onehot0(i_wvb_rdreq) && $onehot0(i_wvb_rddone))
    else $error("channel strobe set on more than one channel");

  // done closes the waveform right behind its last sample read
  a_done_after_last: assert property (@(posedge clk) disable iff (!i_rst_n)
    |i_wvb_rddone |-> $past(i_wvb_rdreq) == i_wvb_rddone)
    else $error("rddone not preceded by the last rdreq of the same channel");

  a_reset_empty: assert property (@(posedge clk) $rose(i_rst_n) |-> i_buf_hdr_empty)
    else $error("header fifo not empty after reset");

endmodule

bind secondary_buffer secondary_buffer_props props0 (
  .clk             (clk),
  .i_rst_n         (i_rst_n),
  .i_wvb_hdr_rdreq (o_wvb_hdr_rdreq),
  .i_wvb_rdreq     (o_wvb_rdreq),
  .i_wvb_rddone    (o_wvb_rddone),
  .i_buf_hdr_empty (o_buf_hdr_empty)
);

`default_nettype wire

// File: dv/secondary_buffer_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "scdb_macros.svh"

module secondary_buffer_tb
  import scdb_data_pkg::*;
();

  localparam int N_CH = `SCDB_N_CHANNELS;
  localparam int MEM_WORDS = 1 << `SCDB_ADDR_W;
  localparam int HDR_DEPTH = 1 << `SCDB_HDR_DEPTH_LOG2;
  localparam int CH_LSB = 2 * `SCDB_ADDR_W;
  localparam int DRIVE_DLY = 2;
  localparam int IDLE_RELEASE = 40;
  localparam int N_GRP = 5;
  localparam int RR_GRP = 1;
  localparam int N_ROWS = 25;

  // group 0 single, 1 round robin, 2 per-channel order, 3 space, 4 header fifo
  localparam int ROW_GRP [N_ROWS] = '{0, 1, 1, 1, 1, 2, 2, 2, 2, 3, 3, 3, 3, 3, 3,
                                      4, 4, 4, 4, 4, 4, 4, 4, 4, 4};
  localparam int ROW_CHAN [N_ROWS] = '{1, 0, 1, 2, 3, 3, 3, 0, 0, 0, 1, 2, 3, 0, 1,
                                       0, 1, 2, 3, 0, 1, 2, 3, 0, 1};
  // samples minus one
  localparam int ROW_LEN [N_ROWS] = '{5, 3, 7, 2, 9, 4, 1, 6, 0, 15, 15, 15, 15, 15, 15,
                                      0, 1, 0, 1, 0, 1, 0, 1, 0, 1};
  localparam int ROW_TAG [N_ROWS] = '{'h101, 'h210, 'h211, 'h212, 'h213,
                                      'h320, 'h321, 'h322, 'h323,
                                      'h430, 'h431, 'h432, 'h433, 'h434, 'h435,
                                      'h540, 'h541, 'h542, 'h543, 'h544,
                                      'h545, 'h546, 'h547, 'h548, 'h549};
  // reader idle cycles before this header is popped
  localparam int ROW_STALL [N_ROWS] = '{0, 0, 3, 0, 1, 0, 2, 0, 5, 0, 0, 0, 0, 0, 0,
                                        200, 0, 0, 0, 0, 0, 0, 0, 0, 0};
  // rddone held back until the buffer runs dry
  localparam int ROW_DELAY [N_ROWS] = '{0, 0, 0, 0, 0, 0, 0, 0, 0, 1, 1, 1, 1, 1, 1,
                                        0, 0, 0, 0, 0, 0, 0, 0, 0, 0};

  logic                          clk;
  logic                          rst_n;
  logic       [N_CH-1:0]         wvb_hdr_empty;
  wvb_hdr_t   [N_CH-1:0]         wvb_hdr_data;
  sample_t    [N_CH-1:0]         wvb_data;
  logic       [N_CH-1:0]         wvb_hdr_rdreq;
  logic       [N_CH-1:0]         wvb_rdreq;
  logic       [N_CH-1:0]         wvb_rddone;
  logic                          buf_hdr_rdreq;
  logic                          buf_rdreq;
  logic                          buf_rddone;
  logic                          buf_hdr_empty;
  scdb_hdr_t                     buf_hdr_data;
  sample_t                       buf_data;

  sample_t    row_smp [N_ROWS][16];
  int         exp_row [N_CH][$];
  scdb_addr_t next_start;
  int         held_words;
  int         fifo_level;
  int         err_cnt;
  int         cycle_cnt;
  int         cycle_limit;

  secondary_buffer dut0 (
    .clk             (clk),
    .i_rst_n         (rst_n),
    .i_wvb_hdr_empty (wvb_hdr_empty),
    .i_wvb_hdr_data  (wvb_hdr_data),
    .i_wvb_data      (wvb_data),
    .o_wvb_hdr_rdreq (wvb_hdr_rdreq),
    .o_wvb_rdreq     (wvb_rdreq),
    .o_wvb_rddone    (wvb_rddone),
    .i_buf_hdr_rdreq (buf_hdr_rdreq),
    .i_buf_rdreq     (buf_rdreq),
    .i_buf_rddone    (buf_rddone),
    .o_buf_hdr_empty (buf_hdr_empty),
    .o_buf_hdr_data  (buf_hdr_data),
    .o_buf_data      (buf_data)
  );

  for (genvar c = 0; c < N_CH; c++) begin : gen_ch
    wvb_channel_model model0 (
      .clk         (clk),
      .i_hdr_rdreq (wvb_hdr_rdreq[c]),
      .i_rdreq     (wvb_rdreq[c]),
      .i_rddone    (wvb_rddone[c]),
      .o_hdr_empty (wvb_hdr_empty[c]),
      .o_hdr_data  (wvb_hdr_data[c]),
      .o_data      (wvb_data[c])
    );
  end

  initial begin
    clk = 1'b0;
    forever begin
      #20 clk = ~clk;
    end
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
      $display("timeout: run did not finish within %0d cycles", cycle_limit);
      $display("SOME TESTS FAILED");
      $fatal(1, "timeout");
    end
  end

  task automatic fail_run();
    err_cnt++;
    $display("SOME TESTS FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic compare_hdr(input string name, input scdb_hdr_t exp, input scdb_hdr_t act);
    if (act !== exp) begin
      $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, act);
      fail_run();
    end
  endtask

  task automatic compare_sample(input string name, input sample_t exp, input sample_t act);
    if (act !== exp) begin
      $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, act);
      fail_run();
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    if (cond !== 1'b1) begin
      $display("check failed at %0t: %s", $time, what);
      fail_run();
    end
  endtask

  // fifo occupancy seen from its write and pop strobes
  always @(negedge clk) begin
    if (rst_n) begin
      fifo_level = fifo_level + dut0.hdr_wren - buf_hdr_rdreq;
      if (fifo_level > HDR_DEPTH) begin
        $display("check failed at %0t: header fifo holds %0d headers", $time, fifo_level);
        fail_run();
      end
    end
  end

  task automatic next_cycle();
    @(posedge clk);
    #DRIVE_DLY;
  endtask

  task automatic push_sample(input int ch, input sample_t s);
    case (ch)
      0: gen_ch[0].model0.add_sample(s);
      1: gen_ch[1].model0.add_sample(s);
      2: gen_ch[2].model0.add_sample(s);
      default: gen_ch[3].model0.add_sample(s);
    endcase
  endtask

  task automatic push_header(input int ch, input wvb_hdr_t h);
    case (ch)
      0: gen_ch[0].model0.add_header(h);
      1: gen_ch[1].model0.add_header(h);
      2: gen_ch[2].model0.add_header(h);
      default: gen_ch[3].model0.add_header(h);
    endcase
  endtask

  task automatic load_row(input int r);
    for (int i = 0; i <= ROW_LEN[r]; i++) begin
      row_smp[r][i] = sample_t'($urandom);
      push_sample(ROW_CHAN[r], row_smp[r][i]);
    end
    push_header(ROW_CHAN[r], {evt_tag_t'(ROW_TAG[r]), wfm_len_t'(ROW_LEN[r])});
    exp_row[ROW_CHAN[r]].push_back(r);
  endtask

  task automatic release_held();
    buf_rddone = 1'b1;
    next_cycle();
    buf_rddone = 1'b0;
    held_words = 0;
  endtask

  // held data is let go once the writer has stalled for a while
  task automatic wait_header();
    int idle;
    idle = 0;
    while (buf_hdr_empty) begin
      next_cycle();
      idle++;
      if (idle >= IDLE_RELEASE && held_words != 0) begin
        release_held();
        idle = 0;
      end
    end
  endtask

  // one request per sample, each answered on the next cycle
  task automatic read_waveform(input int r);
    next_cycle();
    for (int i = 0; i <= ROW_LEN[r]; i++) begin
      buf_rdreq = 1'b1;
      next_cycle();
      compare_sample("o_buf_data", row_smp[r][i], buf_data);
    end
    // one more request past the stop address
    next_cycle();
    buf_rdreq = 1'b0;
    compare_sample("o_buf_data", row_smp[r][ROW_LEN[r]], buf_data);
  endtask

  task automatic drain_header(input int grp, input bit first, inout chan_idx_t prev_ch);
    scdb_hdr_t  act;
    chan_idx_t  ch;
    scdb_addr_t stop;
    int         r;
    buf_hdr_rdreq = 1'b1;
    next_cycle();
    buf_hdr_rdreq = 1'b0;
    act = buf_hdr_data;
    ch = chan_idx_t'(act >> CH_LSB);
    if (grp == RR_GRP && !first) begin
      ch = chan_idx_t'(prev_ch + 1'b1);
    end
    prev_ch = ch;
    check_true(exp_row[ch].size() != 0, "header for a channel with nothing queued");
    r = exp_row[ch].pop_front();
    stop = scdb_addr_t'(next_start + ROW_LEN[r]);
    compare_hdr("o_buf_hdr_data", {evt_tag_t'(ROW_TAG[r]), ch, next_start, stop}, act);
    next_start = scdb_addr_t'(stop + 1'b1);
    check_true(held_words + ROW_LEN[r] + 1 <= MEM_WORDS, "header overruns unreleased data");
    read_waveform(r);
    held_words += ROW_LEN[r] + 1;
    if (ROW_DELAY[r] == 0) begin
      release_held();
    end
  endtask

  initial begin
    int        seed_val;
    int        grp_rows [$];
    chan_idx_t prev_ch;
    seed_val = $urandom(32'h5fad_1e21);
    rst_n = 1'b0;
    buf_hdr_rdreq = 1'b0;
    buf_rdreq = 1'b0;
    buf_rddone = 1'b0;
    next_start = '0;
    held_words = 0;
    fifo_level = 0;
    err_cnt = 0;
    cycle_cnt = 0;
    cycle_limit = 500;
    for (int r = 0; r < N_ROWS; r++) begin
      cycle_limit += (ROW_LEN[r] + 1 + 12) * 4;
    end
    repeat (16) @(posedge clk);
    #DRIVE_DLY;
    rst_n = 1'b1;
    next_cycle();
    check_true(buf_hdr_empty, "header fifo not empty after reset");
    check_true(wvb_hdr_rdreq == '0 && wvb_rdreq == '0 && wvb_rddone == '0,
               "channel strobe active after reset");
    prev_ch = '0;
    for (int g = 0; g < N_GRP; g++) begin
      grp_rows.delete();
      for (int r = 0; r < N_ROWS; r++) begin
        if (ROW_GRP[r] == g) begin
          load_row(r);
          grp_rows.push_back(r);
        end
      end
      for (int k = 0; k < grp_rows.size(); k++) begin
        repeat (ROW_STALL[grp_rows[k]]) next_cycle();
        wait_header();
        drain_header(g, k == 0, prev_ch);
      end
      if (held_words != 0) begin
        release_held();
      end
    end
    // nothing may come out twice
    repeat (50) next_cycle();
    check_true(buf_hdr_empty, "extra header after all waveforms were read");
    check_true(!gen_ch[0].model0.bad_strobe && !gen_ch[1].model0.bad_strobe &&
               !gen_ch[2].model0.bad_strobe && !gen_ch[3].model0.bad_strobe,
               "channel strobe on an empty channel queue");
    check_true(gen_ch[0].model0.done_cnt + gen_ch[1].model0.done_cnt +
               gen_ch[2].model0.done_cnt + gen_ch[3].model0.done_cnt == N_ROWS,
               "number of rddone pulses differs from waveforms sent");
    if (err_cnt == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: secondary_buffer.f
+incdir+common
common/scdb_data_pkg.sv
common/scdb_ctrl_pkg.sv
rtl/chan_finder.sv
scdb_writer/scdb_writer.sv
scdb_storage/scdb_storage.sv
rtl/scdb_reader.sv
rtl/secondary_buffer.sv
dv/wvb_channel_model.sv
dv/secondary_buffer_props.sv
dv/secondary_buffer_tb.sv

// File: Bender.yml
package:
  name: secondary_buffer

export_include_dirs:
  - common

sources:
  - common/scdb_data_pkg.sv
  - common/scdb_ctrl_pkg.sv
  - rtl/chan_finder.sv
  - scdb_writer/scdb_writer.sv
  - scdb_storage/scdb_storage.sv
  - rtl/scdb_reader.sv
  - rtl/secondary_buffer.sv
  - target: test
    files:
      - dv/wvb_channel_model.sv
      - dv/secondary_buffer_props.sv
      - dv/secondary_buffer_tb.sv
